// File: md_pkg.sv
`default_nettype none

package md_pkg;

    // --------------------
    // sizes and latencies
    // --------------------
    localparam int XLEN         = 32;
    localparam int NUM_MD_UNITS = 4;
    localparam int MUL_CYCLES   = 33;  // start strobe to complete
    localparam int DIV_CYCLES   = 34;  // start strobe to complete

    typedef logic [XLEN-1:0] data_t;
    typedef logic [XLEN:0]   wide_t;      // sign-extended operand
    typedef logic [5:0]      rob_id_t;
    typedef logic [6:0]      phy_reg_t;
    typedef logic [4:0]      arch_reg_t;
    typedef logic [1:0]      unit_idx_t;

    // top bit set for the divide group
    typedef enum logic [2:0] {
        MD_MUL    = 3'b000,
        MD_MULH   = 3'b001,
        MD_MULHSU = 3'b010,
        MD_MULHU  = 3'b011,
        MD_DIV    = 3'b100,
        MD_DIVU   = 3'b101,
        MD_REM    = 3'b110,
        MD_REMU   = 3'b111
    } md_op_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_BUSY,
        ENG_DONE
    } eng_state_t;

    // --------------------
    // packets
    // --------------------
    typedef struct packed {
        md_op_t    op;
        data_t     rs1_value;
        data_t     rs2_value;
        rob_id_t   rob_id;
        arch_reg_t rd_arch;
        phy_reg_t  rd_phy;
    } md_req_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        arch_reg_t rd_arch;
        phy_reg_t  rd_phy;
        data_t     rd_value;
        data_t     rs1_value_dbg;  // operand echo for checking
        data_t     rs2_value_dbg;
    } cdb_pkt_t;

endpackage

`default_nettype wire

// File: md_mult.sv
`timescale 1ns/1ps
`default_nettype none

module md_mult import md_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  wide_t              a,
    input  wide_t              b,
    output logic               complete,
    output logic [2*XLEN+1:0]  product
);

    eng_state_t          state;
    logic [5:0]          cnt;
    logic [2*XLEN+1:0]   acc;
    logic [2*XLEN+1:0]   mcand;   // shifted multiplicand
    wide_t               mplier;  // remaining multiplier bits
    logic                last;

    assign last = (cnt == 6'(MUL_CYCLES - 2));  // iteration for the sign bit of b

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENG_IDLE;
            cnt   <= '0;
        end else if (start) begin  // restart from any state
            state <= ENG_BUSY;
            cnt   <= '0;
        end else if (state == ENG_BUSY) begin
            cnt <= cnt + 6'd1;
            if (last) state <= ENG_DONE;
        end
    end

    // --------------------
    // datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            // bit 0 of b is folded into the load
            acc    <= b[0] ? {{(XLEN+1){a[XLEN]}}, a} : '0;
            mcand  <= {{XLEN{a[XLEN]}}, a, 1'b0};
            mplier <= b >> 1;
        end else if (state == ENG_BUSY) begin
            if (mplier[0]) begin
                // msb of b weighs negative in two's complement
                acc <= last ? acc - mcand : acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign complete = (state == ENG_DONE);
    assign product  = acc;

endmodule

`default_nettype wire

// File: md_div.sv
`timescale 1ns/1ps
`default_nettype none

module md_div import md_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  wide_t a,
    input  wide_t b,
    output logic  complete,
    output logic  divide_by_0,
    output wide_t quotient,
    output wide_t remainder
);

    eng_state_t        state;
    logic [5:0]        cnt;
    wide_t             quo;       // dividend shifts out, quotient shifts in
    wide_t             rem_r;     // partial remainder
    wide_t             dsr;       // divisor magnitude
    logic              neg_q, neg_r;
    logic              div0;
    logic [XLEN+1:0]   shifted;
    logic [XLEN+2:0]   diff;

    function automatic wide_t mag(input wide_t v);
        return v[XLEN] ? -v : v;
    endfunction

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENG_IDLE;
            cnt   <= '0;
        end else if (start) begin
            state <= ENG_BUSY;
            cnt   <= '0;
        end else if (state == ENG_BUSY) begin
            cnt <= cnt + 6'd1;
            if (cnt == 6'(DIV_CYCLES - 2)) state <= ENG_DONE;  // one quotient bit per cycle
        end
    end

    // --------------------
    // restoring step
    // --------------------
    assign shifted = {rem_r, quo[XLEN]};
    assign diff    = {1'b0, shifted} - {2'b00, dsr};  // msb set means restore

    always_ff @(posedge clk) begin
        if (start) begin
            quo   <= mag(a);
            dsr   <= mag(b);
            rem_r <= '0;
            neg_q <= a[XLEN] ^ b[XLEN];
            neg_r <= a[XLEN];  // remainder follows the dividend
            div0  <= (b == '0);
        end else if (state == ENG_BUSY) begin
            if (diff[XLEN+2]) begin
                rem_r <= shifted[XLEN:0];
            end else begin
                rem_r <= diff[XLEN:0];
            end
            quo <= {quo[XLEN-1:0], ~diff[XLEN+2]};
        end
    end

    // sign correction on the way out
    assign quotient    = neg_q ? -quo : quo;
    assign remainder   = neg_r ? -rem_r : rem_r;
    assign divide_by_0 = div0;
    assign complete    = (state == ENG_DONE);

endmodule

`default_nettype wire

// File: fu_md.sv
`timescale 1ns/1ps
`default_nettype none

module fu_md import md_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,

    input  logic     prv_valid,
    output logic     prv_ready,

    output logic     nxt_valid,
    input  logic     nxt_ready,

    input  md_req_t  req_in,
    output cdb_pkt_t result
);

    md_req_t             req_reg;
    logic                reg_valid;
    logic                reg_start;

    logic                is_multiply;
    logic                mul_start, div_start;
    wide_t               a, b;
    wide_t               as, au, bs, bu;

    logic                mul_complete, div_complete;
    logic [2*XLEN+1:0]   product;
    wide_t               quotient, remainder;
    logic                divide_by_0;
    logic                complete;
    data_t               outcome;

    // --------------------
    // input register
    // --------------------
    // free again once the held result is taken
    assign prv_ready = ~reg_valid || (nxt_valid && nxt_ready);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            reg_valid <= 1'b0;
            reg_start <= 1'b0;
        end else begin
            if (prv_ready) reg_valid <= prv_valid;
            reg_start <= prv_valid && prv_ready;  // single cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (prv_valid && prv_ready) req_reg <= req_in;
    end

    // --------------------
    // operands
    // --------------------
    assign is_multiply = ~req_reg.op[2];
    assign mul_start   = reg_start && is_multiply;
    assign div_start   = reg_start && ~is_multiply;

    assign as = {req_reg.rs1_value[XLEN-1], req_reg.rs1_value};
    assign au = {1'b0, req_reg.rs1_value};
    assign bs = {req_reg.rs2_value[XLEN-1], req_reg.rs2_value};
    assign bu = {1'b0, req_reg.rs2_value};

    always_comb begin
        a = as;
        b = bs;
        outcome = quotient[XLEN-1:0];
        unique case (req_reg.op)
            MD_MUL:    outcome = product[XLEN-1:0];
            MD_MULH:   outcome = product[2*XLEN-1:XLEN];
            MD_MULHSU: begin
                b = bu;
                outcome = product[2*XLEN-1:XLEN];
            end
            MD_MULHU: begin
                a = au;
                b = bu;
                outcome = product[2*XLEN-1:XLEN];
            end
            // most negative / -1 falls out of the magnitudes as is
            MD_DIV:    outcome = divide_by_0 ? '1 : quotient[XLEN-1:0];
            MD_DIVU: begin
                a = au;
                b = bu;
                outcome = divide_by_0 ? '1 : quotient[XLEN-1:0];
            end
            MD_REM:    outcome = divide_by_0 ? req_reg.rs1_value : remainder[XLEN-1:0];
            MD_REMU: begin
                a = au;
                b = bu;
                outcome = divide_by_0 ? req_reg.rs1_value : remainder[XLEN-1:0];
            end
            default: ;
        endcase
    end

    // --------------------
    // engines
    // --------------------
    md_mult u_mult (
        .clk      (clk),
        .rst      (rst),
        .start    (mul_start),
        .a        (a),
        .b        (b),
        .complete (mul_complete),
        .product  (product)
    );

    md_div u_div (
        .clk         (clk),
        .rst         (rst),
        .start       (div_start),
        .a           (a),
        .b           (b),
        .complete    (div_complete),
        .divide_by_0 (divide_by_0),
        .quotient    (quotient),
        .remainder   (remainder)
    );

    // stale done flag still up while the strobe is out
    assign complete  = (is_multiply ? mul_complete : div_complete) && ~reg_start;
    assign nxt_valid = reg_valid && complete;

    // result holds while the engine sits in done
    always_comb begin
        result.valid         = nxt_valid;
        result.rob_id        = req_reg.rob_id;
        result.rd_arch       = req_reg.rd_arch;
        result.rd_phy        = req_reg.rd_phy;
        result.rd_value      = outcome;
        result.rs1_value_dbg = req_reg.rs1_value;
        result.rs2_value_dbg = req_reg.rs2_value;
    end

endmodule

`default_nettype wire

// File: md_issue.sv
`timescale 1ns/1ps
`default_nettype none

module md_issue import md_pkg::*; (
    input  logic                    issue_valid,
    output logic                    issue_ready,
    input  logic [NUM_MD_UNITS-1:0] unit_ready,
    output logic [NUM_MD_UNITS-1:0] unit_valid
);

    // any free unit can take the op
    assign issue_ready = |unit_ready;

    // lowest free index wins
    always_comb begin
        logic taken;
        taken      = 1'b0;
        unit_valid = '0;
        for (int i = 0; i < NUM_MD_UNITS; i++) begin
            if (unit_ready[i] && !taken) begin
                unit_valid[i] = issue_valid;
                taken         = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: cdb_arb.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arb import md_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic [NUM_MD_UNITS-1:0] req,
    input  cdb_pkt_t                unit_result [NUM_MD_UNITS],
    output logic [NUM_MD_UNITS-1:0] grant,
    output cdb_pkt_t                cdb
);

    unit_idx_t ptr;      // first unit to look at
    unit_idx_t winner;
    logic      found;

    // --------------------
    // round-robin pick
    // --------------------
    always_comb begin
        unit_idx_t idx;
        grant  = '0;
        winner = ptr;
        found  = 1'b0;
        for (int k = 0; k < NUM_MD_UNITS; k++) begin
            idx = unit_idx_t'(int'(ptr) + k);  // wraps around
            if (!flush && !found && req[idx]) begin
                grant[idx] = 1'b1;
                winner     = idx;
                found      = 1'b1;
            end
        end
    end

    // --------------------
    // registered broadcast
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= winner + unit_idx_t'(1);  // skip past the winner
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cdb <= '0;
        end else if (found) begin
            cdb       <= unit_result[winner];
            cdb.valid <= 1'b1;
        end else begin
            cdb.valid <= 1'b0;  // one beat per result
        end
    end

endmodule

`default_nettype wire

// File: md_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module md_cluster import md_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     issue_valid,
    output logic     issue_ready,
    input  md_req_t  issue_req,
    output cdb_pkt_t cdb
);

    logic [NUM_MD_UNITS-1:0] unit_valid;   // issue strobe per unit
    logic [NUM_MD_UNITS-1:0] unit_ready;
    logic [NUM_MD_UNITS-1:0] done_valid;   // finished and waiting
    logic [NUM_MD_UNITS-1:0] grant;
    cdb_pkt_t                unit_result [NUM_MD_UNITS];

    md_issue u_issue (
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .unit_ready  (unit_ready),
        .unit_valid  (unit_valid)
    );

    for (genvar i = 0; i < NUM_MD_UNITS; i++) begin : g_unit
        fu_md u_fu (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .prv_valid (unit_valid[i]),
            .prv_ready (unit_ready[i]),
            .nxt_valid (done_valid[i]),
            .nxt_ready (grant[i]),
            .req_in    (issue_req),  // same request to every unit
            .result    (unit_result[i])
        );
    end

    cdb_arb u_arb (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .req         (done_valid),
        .unit_result (unit_result),
        .grant       (grant),
        .cdb         (cdb)
    );

endmodule

`default_nettype wire

// File: md_cluster_sva.sv
`timescale 1ns/1ps
`default_nettype none

module md_cluster_sva import md_pkg::*; (
    input logic                    clk,
    input logic                    rst,
    input logic                    flush,
    input logic                    issue_valid,
    input logic                    issue_ready,
    input logic [NUM_MD_UNITS-1:0] unit_valid,
    input logic [NUM_MD_UNITS-1:0] done_valid,
    input logic [NUM_MD_UNITS-1:0] grant,
    input logic                    cdb_valid,
    input cdb_pkt_t                unit_result [NUM_MD_UNITS]
);

    int fail_count = 0;  // failed assertions so far

    // --------------------
    // reset and flush
    // --------------------
    a_rst_quiet: assert property (@(posedge clk) rst |=> !cdb_valid)
        else begin
            fail_count++;
            $error("cdb valid during reset");
        end
    a_flush_quiet: assert property (@(posedge clk) flush |=> !cdb_valid)
        else begin
            fail_count++;
            $error("cdb valid in the cycle after flush");
        end

    // --------------------
    // arbiter and issue
    // --------------------
    a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else begin
            fail_count++;
            $error("more than one unit granted");
        end
    a_accept_onehot: assert property (@(posedge clk) disable iff (rst)
        issue_valid && issue_ready |-> $onehot(unit_valid))
        else begin
            fail_count++;
            $error("issue accept not one-hot over units");
        end

    // held result must not move until granted
    for (genvar i = 0; i < NUM_MD_UNITS; i++) begin : g_hold
        a_hold: assert property (@(posedge clk) disable iff (rst || flush)
            done_valid[i] && !grant[i] |=> done_valid[i] && $stable(unit_result[i]))
            else begin
                fail_count++;
                $error("unit %0d dropped or changed its result", i);
            end
    end

endmodule

bind md_cluster md_cluster_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .unit_valid  (unit_valid),
    .done_valid  (done_valid),
    .grant       (grant),
    .cdb_valid   (cdb.valid),
    .unit_result (unit_result)
);

`default_nettype wire

// File: tb_md_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_md_cluster import md_pkg::*; ();

    localparam int N_OPS    = 400;  // upper bound on issued micro-ops
    localparam int WD_LIMIT = N_OPS * (DIV_CYCLES + 2 + NUM_MD_UNITS) + 200;

    logic     clk;
    logic     rst;
    logic     flush;
    logic     issue_valid;
    logic     issue_ready;
    md_req_t  issue_req;
    cdb_pkt_t cdb;

    // scoreboard indexed by rob_id
    logic      pending  [64];
    data_t     exp_val  [64];
    data_t     exp_rs1  [64];
    data_t     exp_rs2  [64];
    arch_reg_t exp_arch [64];
    phy_reg_t  exp_phy  [64];

    int      seed = 8731;
    int      errors = 0;
    int      checks = 0;
    int      killed = 0;
    int      outstanding = 0;
    int      total_fail;
    rob_id_t next_rob = '0;
    data_t   corner [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    md_cluster u_dut (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_req   (issue_req),
        .cdb         (cdb)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // --------------------
    // reference model
    // --------------------
    function automatic data_t model_result(md_op_t op, data_t rs1, data_t rs2);
        longint      s1, s2;
        logic [63:0] u1, u2, p;
        s1 = longint'($signed(rs1));
        s2 = longint'($signed(rs2));
        u1 = {32'h0, rs1};
        u2 = {32'h0, rs2};
        if (!op[2]) begin
            case (op)
                MD_MUL, MD_MULH: p = s1 * s2;
                MD_MULHSU:       p = s1 * u2;  // exact, fits in 64 bits
                default:         p = u1 * u2;
            endcase
            return (op == MD_MUL) ? p[31:0] : p[63:32];
        end
        if (rs2 == 32'h0) return (op == MD_DIV || op == MD_DIVU) ? 32'hffff_ffff : rs1;
        if (rs1 == 32'h8000_0000 && rs2 == 32'hffff_ffff) begin
            if (op == MD_DIV) return 32'h8000_0000;
            if (op == MD_REM) return 32'h0;
        end
        case (op)
            MD_DIV:  p = s1 / s2;  // truncates toward zero
            MD_DIVU: p = u1 / u2;
            MD_REM:  p = s1 % s2;  // sign of the dividend
            default: p = u1 % u2;
        endcase
        return p[31:0];
    endfunction

    task automatic report_mismatch(input string name, input data_t exp, input data_t got);
        errors++;
        $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
    endtask

    // --------------------
    // cdb monitor
    // --------------------
    task automatic check_cdb();
        rob_id_t id;
        id = cdb.rob_id;
        checks++;
        assert (pending[id]) else begin
            errors++;
            $display("rob_id %0d on cdb at %0t was not expected (flushed or repeated)",
                     id, $time);
        end
        if (pending[id]) begin
            assert (cdb.rd_value == exp_val[id])
                else report_mismatch("cdb.rd_value", exp_val[id], cdb.rd_value);
            assert (cdb.rd_arch == exp_arch[id])
                else report_mismatch("cdb.rd_arch", 32'(exp_arch[id]), 32'(cdb.rd_arch));
            assert (cdb.rd_phy == exp_phy[id])
                else report_mismatch("cdb.rd_phy", 32'(exp_phy[id]), 32'(cdb.rd_phy));
            assert (cdb.rs1_value_dbg == exp_rs1[id])
                else report_mismatch("cdb.rs1_value_dbg", exp_rs1[id], cdb.rs1_value_dbg);
            assert (cdb.rs2_value_dbg == exp_rs2[id])
                else report_mismatch("cdb.rs2_value_dbg", exp_rs2[id], cdb.rs2_value_dbg);
            pending[id] = 1'b0;
            outstanding--;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && cdb.valid) check_cdb();
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic send_op(input md_op_t op, input data_t rs1, input data_t rs2);
        rob_id_t id;
        id = next_rob;
        next_rob++;
        issue_req.op        = op;
        issue_req.rs1_value = rs1;
        issue_req.rs2_value = rs2;
        issue_req.rob_id    = id;
        issue_req.rd_arch   = arch_reg_t'($random(seed));
        issue_req.rd_phy    = phy_reg_t'($random(seed));
        issue_valid = 1'b1;
        while (!issue_ready) @(negedge clk);
        @(posedge clk);
        pending[id]  = 1'b1;  // accepted on this edge
        exp_val[id]  = model_result(op, rs1, rs2);
        exp_rs1[id]  = rs1;
        exp_rs2[id]  = rs2;
        exp_arch[id] = issue_req.rd_arch;
        exp_phy[id]  = issue_req.rd_phy;
        outstanding++;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic pick_operand(output data_t v);
        if (($random(seed) & 3) == 0) v = corner[($random(seed) & 32'h7fff) % 5];
        else v = data_t'($random(seed));
    endtask

    task automatic drain();
        while (outstanding != 0) @(negedge clk);
    endtask

    // everything not yet on cdb dies, the beat already on cdb stays
    task automatic flush_pipeline();
        for (int i = 0; i < 64; i++) begin
            if (pending[i] && !(cdb.valid && cdb.rob_id == rob_id_t'(i))) begin
                pending[i] = 1'b0;
                outstanding--;
                killed++;
            end
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    initial begin
        data_t r1, r2;
        for (int i = 0; i < 64; i++) pending[i] = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_req   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset
        repeat (2) begin
            @(negedge clk);
            assert (issue_ready) else begin
                errors++;
                $display("issue_ready low after reset at %0t", $time);
            end
            assert (!cdb.valid) else begin
                errors++;
                $display("cdb valid after reset with nothing issued at %0t", $time);
            end
        end

        // corner operands on all eight ops
        for (int op = 0; op < 8; op++)
            for (int i = 0; i < 5; i++)
                for (int j = 0; j < 5; j++)
                    send_op(md_op_t'(op), corner[i], corner[j]);
        drain();

        // fill every unit, then issue must stall
        for (int k = 0; k < NUM_MD_UNITS; k++) send_op(MD_DIV, data_t'($random(seed)), 32'd7);
        assert (!issue_ready) else begin
            errors++;
            $display("issue_ready still high with all units busy at %0t", $time);
        end
        drain();

        // div then mul pairs finish in the same cycle
        send_op(MD_DIV, 32'd1000, 32'd3);
        send_op(MD_MUL, 32'd1234, 32'd5678);
        send_op(MD_REMU, 32'hdead_beef, 32'd17);
        send_op(MD_MULHU, 32'hffff_ffff, 32'hffff_ffff);
        drain();

        // flush with work in flight
        send_op(MD_DIV, 32'd99, 32'd9);
        send_op(MD_MULH, 32'h8000_0000, 32'h8000_0000);
        send_op(MD_REM, 32'hffff_fff0, 32'd3);
        send_op(MD_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
        repeat (10) @(negedge clk);
        flush_pipeline();
        repeat (50) @(negedge clk);  // killed engines run out here
        for (int k = 0; k < NUM_MD_UNITS; k++) send_op(md_op_t'(k * 2), 32'd77, 32'd5);
        drain();

        // random mix, with one flush half way
        for (int n = 0; n < 150; n++) begin
            pick_operand(r1);
            pick_operand(r2);
            send_op(md_op_t'($random(seed) & 7), r1, r2);
            if (n == 75) flush_pipeline();
        end
        drain();
        repeat (5) @(negedge clk);

        total_fail = errors + u_dut.u_sva.fail_count;
        $display("checks %0d  errors %0d  assertion failures %0d  flushed %0d",
                 checks, errors, u_dut.u_sva.fail_count, killed);
        if (total_fail == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // --------------------
    // watchdog
    // --------------------
    initial begin
        repeat (WD_LIMIT) @(posedge clk);
        $display("timeout after %0d cycles, results never arrived, %0d still outstanding",
                 WD_LIMIT, outstanding);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
md_pkg.sv
md_mult.sv
md_div.sv
fu_md.sv
md_issue.sv
cdb_arb.sv
md_cluster.sv
md_cluster_sva.sv
tb_md_cluster.sv
